//--- filelist.f
+incdir+src
src/fetch_pkg.sv
src/fetch_if.sv
src/branch_predictor.sv
src/pc_generator.sv
src/instr_queue.sv
src/fetch_issue.sv
src/fetch_top.sv
verification/fetch_sva.sv
verification/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
verilator --binary --timing -Wno-fatal -f filelist.f --top-module fetch_tb -o fetch_sim &&
./obj_dir/fetch_sim | tee /dev/stderr | grep "PASS: all tests" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- src/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_predictor (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] lookup_pc_i,
    output logic        pred_taken_o,
    output logic [31:0] pred_target_o,
    input  logic        update_valid_i,
    input  logic [31:0] update_pc_i,
    input  logic        update_taken_i,
    input  logic [31:0] update_target_i
);

    localparam int ENTRIES = `FETCH_BTB_ENTRIES;
    localparam int IW      = $clog2(ENTRIES);

    fetch_pkg::ctr_state_e ctr_q [ENTRIES];
    logic [31:0]           target_q [ENTRIES];
    logic [ENTRIES-1:0]    valid_q;

    logic [IW-1:0]         lookup_idx;
    logic [IW-1:0]         update_idx;
    fetch_pkg::ctr_state_e ctr_next;

    assign lookup_idx = lookup_pc_i[IW+1:2];
    assign update_idx = update_pc_i[IW+1:2];

    assign pred_taken_o  = valid_q[lookup_idx] &&
                           (ctr_q[lookup_idx] == fetch_pkg::WEAK_T ||
                            ctr_q[lookup_idx] == fetch_pkg::STRONG_T);
    assign pred_target_o = target_q[lookup_idx];

    // one step toward the resolved outcome.
    always_comb begin
        ctr_next = ctr_q[update_idx];
        case (ctr_q[update_idx])
            fetch_pkg::STRONG_NT: ctr_next = update_taken_i ? fetch_pkg::WEAK_NT
                                                            : fetch_pkg::STRONG_NT;
            fetch_pkg::WEAK_NT:   ctr_next = update_taken_i ? fetch_pkg::WEAK_T
                                                            : fetch_pkg::STRONG_NT;
            fetch_pkg::WEAK_T:    ctr_next = update_taken_i ? fetch_pkg::STRONG_T
                                                            : fetch_pkg::WEAK_NT;
            fetch_pkg::STRONG_T:  ctr_next = update_taken_i ? fetch_pkg::STRONG_T
                                                            : fetch_pkg::WEAK_T;
            default:              ctr_next = fetch_pkg::WEAK_NT;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= fetch_pkg::WEAK_NT;
            end
            valid_q <= '0;
        end else if (update_valid_i) begin
            ctr_q[update_idx] <= ctr_next;
            if (update_taken_i) begin
                valid_q[update_idx] <= 1'b1; // entry holds a target from now on.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_valid_i && update_taken_i) begin
            target_q[update_idx] <= update_target_i;
        end
    end

endmodule

//--- src/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;

    fetch_pkg::fetch_entry_t entry;
    logic                    entry_valid;
    logic                    pop;   // only while entry_valid is high.
    logic                    flush; // empties the queue on the next edge.

    modport queue (
        output entry,
        output entry_valid,
        input  pop,
        input  flush
    );

    modport issue (
        input  entry,
        input  entry_valid,
        output pop,
        output flush
    );

endinterface

//--- src/fetch_issue.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_issue (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic        redirect_valid_i,
    fetch_if.issue      q,
    output logic        jal_redirect_o,
    output logic [31:0] jal_target_o,
    output logic [31:0] pc_o,
    output logic [31:0] instr_o,
    output logic        pred_taken_o,
    output logic        instr_valid_o
);

    fetch_pkg::opcode_e opcode;
    logic [31:0]        j_imm;

    always_comb begin
        case (q.entry.instr[6:0])
            7'b1101111: opcode = fetch_pkg::OP_JAL;
            7'b1100011: opcode = fetch_pkg::OP_BRANCH;
            default:    opcode = fetch_pkg::OP_OTHER;
        endcase
    end

    assign j_imm = {{12{q.entry.instr[31]}}, q.entry.instr[19:12], q.entry.instr[20],
                    q.entry.instr[30:21], 1'b0};

    assign q.pop = q.entry_valid && !stall_i && !redirect_valid_i;

    // a jal the predictor missed is resolved here.
    assign jal_redirect_o = q.pop && (opcode == fetch_pkg::OP_JAL) && !q.entry.pred_taken;
    assign jal_target_o   = q.entry.pc + j_imm;
    assign q.flush        = redirect_valid_i || jal_redirect_o;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pc_o          <= `FETCH_RESET_PC;
            instr_o       <= `FETCH_NOP;
            pred_taken_o  <= 1'b0;
            instr_valid_o <= 1'b0;
        end else if (!stall_i) begin
            if (q.pop) begin
                pc_o          <= q.entry.pc;
                instr_o       <= q.entry.instr;
                pred_taken_o  <= q.entry.pred_taken;
                instr_valid_o <= 1'b1;
            end else begin
                instr_o       <= `FETCH_NOP; // bubble.
                pred_taken_o  <= 1'b0;
                instr_valid_o <= 1'b0;
            end
        end
    end

endmodule

//--- src/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// queue slots and the starting credit count.
`define FETCH_QUEUE_DEPTH 4

// predictor entries indexed by pc bits above bit 1.
`define FETCH_BTB_ENTRIES 16

`define FETCH_RESET_PC 32'h0000_0000

// addi x0, x0, 0.
`define FETCH_NOP 32'h0000_0013

`endif

//--- src/fetch_pkg.sv
package fetch_pkg;

    // predecode class of a fetched word.
    typedef enum logic [1:0] {
        OP_JAL    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_OTHER  = 2'd2
    } opcode_e;

    // two-bit saturating counter.
    typedef enum logic [1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1,
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } ctr_state_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        pred_taken;
    } fetch_entry_t;

endpackage

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic        clk_i,
    input  logic        rst_i,
    output logic        imem_req_o,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_rdata_i,
    input  logic        stall_i,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        update_valid_i,
    input  logic [31:0] update_pc_i,
    input  logic        update_taken_i,
    input  logic [31:0] update_target_i,
    output logic [31:0] pc_o,
    output logic [31:0] instr_o,
    output logic        pred_taken_o,
    output logic        instr_valid_o
);

    logic        req_fire;
    logic [31:0] req_pc;
    logic        req_pred_taken;
    logic        credit_return;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic        jal_redirect;
    logic [31:0] jal_target;

    fetch_if fetch_q ();

    assign imem_req_o  = req_fire;
    assign imem_addr_o = req_pc;

    branch_predictor bp_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_pc_i    (req_pc),
        .pred_taken_o   (pred_taken),
        .pred_target_o  (pred_target),
        .update_valid_i (update_valid_i),
        .update_pc_i    (update_pc_i),
        .update_taken_i (update_taken_i),
        .update_target_i(update_target_i)
    );

    pc_generator pcg_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .redirect_valid_i(redirect_valid_i),
        .redirect_pc_i   (redirect_pc_i),
        .jal_redirect_i  (jal_redirect),
        .jal_target_i    (jal_target),
        .credit_return_i (credit_return),
        .pred_taken_i    (pred_taken),
        .pred_target_i   (pred_target),
        .req_fire_o      (req_fire),
        .req_pc_o        (req_pc),
        .req_pred_taken_o(req_pred_taken)
    );

    instr_queue iq_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_fire_i      (req_fire),
        .req_pc_i        (req_pc),
        .req_pred_taken_i(req_pred_taken),
        .rsp_data_i      (imem_rdata_i),
        .credit_return_o (credit_return),
        .q               (fetch_q.queue)
    );

    fetch_issue fi_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .redirect_valid_i(redirect_valid_i),
        .q               (fetch_q.issue),
        .jal_redirect_o  (jal_redirect),
        .jal_target_o    (jal_target),
        .pc_o            (pc_o),
        .instr_o         (instr_o),
        .pred_taken_o    (pred_taken_o),
        .instr_valid_o   (instr_valid_o)
    );

endmodule

//--- src/instr_queue.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module instr_queue (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_fire_i,
    input  logic [31:0] req_pc_i,
    input  logic        req_pred_taken_i,
    input  logic [31:0] rsp_data_i,
    output logic        credit_return_o,
    fetch_if.queue      q
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = AW + 1;

    fetch_pkg::fetch_entry_t mem [DEPTH];
    fetch_pkg::fetch_entry_t push_entry;

    logic          rsp_valid_q;
    logic [31:0]   rsp_pc_q;
    logic          rsp_pred_q;
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic [CW-1:0] pending_q; // credits still owed to the pc generator.
    logic [CW-1:0] pending_d;
    logic          push;

    assign push = rsp_valid_q && !q.flush;

    assign push_entry.pc         = rsp_pc_q;
    assign push_entry.instr      = rsp_data_i;
    assign push_entry.pred_taken = rsp_pred_q;

    assign q.entry       = mem[rd_ptr_q];
    assign q.entry_valid = (count_q != '0);

    assign credit_return_o = q.pop || (pending_q != '0);

    always_comb begin
        pending_d = pending_q + CW'(q.pop) - CW'(credit_return_o);
        if (q.flush) begin
            // every slot left after the pop, plus the dropped response.
            pending_d = pending_d + count_q - CW'(q.pop) + CW'(rsp_valid_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rsp_valid_q <= 1'b0;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            pending_q   <= '0;
        end else begin
            rsp_valid_q <= req_fire_i;
            pending_q   <= pending_d;
            if (q.flush) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (q.pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                count_q <= count_q + CW'(push) - CW'(q.pop);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_pc_q   <= req_pc_i;
        rsp_pred_q <= req_pred_taken_i;
        if (push) begin
            mem[wr_ptr_q] <= push_entry;
        end
    end

endmodule

//--- src/pc_generator.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module pc_generator (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        jal_redirect_i,
    input  logic [31:0] jal_target_i,
    input  logic        credit_return_i,
    input  logic        pred_taken_i,
    input  logic [31:0] pred_target_i,
    output logic        req_fire_o,
    output logic [31:0] req_pc_o,
    output logic        req_pred_taken_o
);

    localparam int CW = $clog2(`FETCH_QUEUE_DEPTH) + 1;

    logic [31:0]   pc_q;
    logic [31:0]   pc_d;
    logic [CW-1:0] credits_q;
    logic [CW-1:0] credits_d;

    // a credit returned this cycle can be spent at once.
    assign req_fire_o = rst_i && (credits_q != '0 || credit_return_i) &&
                        !redirect_valid_i && !jal_redirect_i;
    assign req_pc_o         = pc_q;
    assign req_pred_taken_o = pred_taken_i;

    always_comb begin
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (jal_redirect_i) begin
            pc_d = jal_target_i;
        end else if (req_fire_o && pred_taken_i) begin
            pc_d = pred_target_i;
        end else if (req_fire_o) begin
            pc_d = pc_q + 32'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    assign credits_d = credits_q - CW'(req_fire_o) + CW'(credit_return_i);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pc_q      <= `FETCH_RESET_PC;
            credits_q <= CW'(`FETCH_QUEUE_DEPTH);
        end else begin
            pc_q      <= pc_d;
            credits_q <= credits_d;
        end
    end

endmodule

//--- verification/fetch_sva.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_sva (
    input logic        clk_i,
    input logic        rst_i,
    input logic        imem_req_o,
    input logic [31:0] imem_addr_o,
    input logic        stall_i,
    input logic        redirect_valid_i,
    input logic [31:0] redirect_pc_i,
    input logic [31:0] pc_o,
    input logic [31:0] instr_o,
    input logic        instr_valid_o
);

    // no fetch request while reset is held.
    a_req_in_reset: assert property (@(posedge clk_i) !rst_i |-> !imem_req_o)
        else $error("imem_req_o high during reset");

    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        stall_i |=> $stable(pc_o) && $stable(instr_o) && $stable(instr_valid_o))
        else $error("outputs moved under stall");

    a_bubble_nop: assert property (@(posedge clk_i) disable iff (!rst_i)
        !instr_valid_o |-> instr_o == `FETCH_NOP)
        else $error("bubble without nop word");

    a_redirect_req: assert property (@(posedge clk_i) disable iff (!rst_i)
        $past(redirect_valid_i) && !redirect_valid_i |-> imem_req_o &&
            imem_addr_o == $past(redirect_pc_i))
        else $error("first request after redirect has wrong address");

endmodule

bind fetch_top fetch_sva sva_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .imem_req_o      (imem_req_o),
    .imem_addr_o     (imem_addr_o),
    .stall_i         (stall_i),
    .redirect_valid_i(redirect_valid_i),
    .redirect_pc_i   (redirect_pc_i),
    .pc_o            (pc_o),
    .instr_o         (instr_o),
    .instr_valid_o   (instr_valid_o)
);

//--- verification/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb;

    localparam int TIMEOUT = 2000;
    localparam logic [31:0] JAL_PC = 32'h200;
    localparam logic [31:0] BR_PC  = 32'h300;
    localparam logic [31:0] BR_TGT = 32'h104;

    logic        clk_i;
    logic        rst_i;
    logic        imem_req_o;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        stall_i;
    logic        redirect_valid_i;
    logic [31:0] redirect_pc_i;
    logic        update_valid_i;
    logic [31:0] update_pc_i;
    logic        update_taken_i;
    logic [31:0] update_target_i;
    logic [31:0] pc_o;
    logic [31:0] instr_o;
    logic        pred_taken_o;
    logic        instr_valid_o;

    integer      seed;
    int          errors;
    int          n_checked;
    logic        rand_stall;
    logic        stall_seen;
    logic        prev_valid;
    logic [31:0] exp_pc;
    logic [31:0] last_pc;
    logic [31:0] prog [256];
    fetch_pkg::fetch_entry_t cur_e, exp_e, prev_e;
    fetch_pkg::ctr_state_e   m_ctr [`FETCH_BTB_ENTRIES];
    logic                    m_valid [`FETCH_BTB_ENTRIES];
    logic [31:0]             m_tgt [`FETCH_BTB_ENTRIES];

    fetch_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] make_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    // inverse of make_jal, sign extended.
    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        logic [20:0] imm;
        imm[20]    = w[31];
        imm[10:1]  = w[30:21];
        imm[11]    = w[20];
        imm[19:12] = w[19:12];
        imm[0]     = 1'b0;
        return {{11{imm[20]}}, imm};
    endfunction

    // saturating two-bit counter of the reference model.
    function automatic fetch_pkg::ctr_state_e ctr_step(input fetch_pkg::ctr_state_e c,
                                                      input logic taken);
        case (c)
            fetch_pkg::STRONG_NT: return taken ? fetch_pkg::WEAK_NT : fetch_pkg::STRONG_NT;
            fetch_pkg::WEAK_NT:   return taken ? fetch_pkg::WEAK_T : fetch_pkg::STRONG_NT;
            fetch_pkg::WEAK_T:    return taken ? fetch_pkg::STRONG_T : fetch_pkg::WEAK_NT;
            default:              return taken ? fetch_pkg::STRONG_T : fetch_pkg::WEAK_T;
        endcase
    endfunction

    task automatic check_entry(input string name, input fetch_pkg::fetch_entry_t got,
                               input fetch_pkg::fetch_entry_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got pc=%h instr=%h pred=%b, expected pc=%h instr=%h pred=%b",
                     $time, name, got.pc, got.instr, got.pred_taken,
                     exp.pc, exp.instr, exp.pred_taken);
        end
    endtask

    task automatic check_pred(input string name, input fetch_pkg::ctr_state_e got,
                              input fetch_pkg::ctr_state_e exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %s, expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic wait_instrs(input int n);
        int start;
        int cyc;
        start = n_checked;
        cyc = 0;
        while (n_checked < start + n && cyc < TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
        end
        if (n_checked < start + n) timeout_fail("valid instructions");
    endtask

    task automatic wait_pc(input logic [31:0] pc);
        int cyc;
        int seen_n;
        logic found;
        cyc = 0;
        seen_n = n_checked;
        found = 1'b0;
        while (!found && cyc < TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
            if (n_checked != seen_n) begin
                seen_n = n_checked;
                found = (last_pc == pc);
            end
        end
        if (!found) timeout_fail("an instruction at the expected pc");
    endtask

    task automatic redirect_cycle(input logic [31:0] pc, input logic upd, input logic taken);
        @(posedge clk_i);
        redirect_valid_i <= 1'b1;
        redirect_pc_i    <= pc;
        update_valid_i   <= upd;
        update_pc_i      <= BR_PC;
        update_taken_i   <= taken;
        update_target_i  <= BR_TGT;
        @(posedge clk_i);
        redirect_valid_i <= 1'b0;
        update_valid_i   <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    // instruction memory with one cycle of latency.
    always @(posedge clk_i) begin
        if (imem_req_o) imem_rdata_i <= prog[imem_addr_o[9:2]];
        stall_i <= rand_stall ? seed_bit() : 1'b0;
    end

    function automatic logic seed_bit();
        return $random(seed) & 1;
    endfunction

    // monitor and reference model.
    always @(posedge clk_i) begin
        cur_e = {pc_o, instr_o, pred_taken_o};
        if (rst_i) begin
            if (stall_seen) begin
                check_entry("held outputs", cur_e, prev_e);
                if (instr_valid_o !== prev_valid) begin
                    errors++;
                    $display("Mismatch at %0t: instr_valid_o got %b, expected %b",
                             $time, instr_valid_o, prev_valid);
                end
            end else if (instr_valid_o) begin
                exp_e = {exp_pc, prog[exp_pc[9:2]],
                         m_valid[exp_pc[5:2]] && m_ctr[exp_pc[5:2]] >= fetch_pkg::WEAK_T};
                check_entry("pc_o/instr_o", cur_e, exp_e);
                if (exp_e.pred_taken) exp_pc = m_tgt[exp_pc[5:2]];
                else if (exp_e.instr[6:0] == 7'b1101111) exp_pc = exp_pc + jal_offset(exp_e.instr);
                else exp_pc = exp_pc + 32'd4;
                last_pc = pc_o;
                n_checked++;
            end
            if (redirect_valid_i) exp_pc = redirect_pc_i;
            if (update_valid_i) begin
                m_ctr[update_pc_i[5:2]] = ctr_step(m_ctr[update_pc_i[5:2]], update_taken_i);
                if (update_taken_i) begin
                    m_valid[update_pc_i[5:2]] = 1'b1;
                    m_tgt[update_pc_i[5:2]] = update_target_i;
                end
            end
        end
        prev_e = cur_e;
        prev_valid = instr_valid_o;
        stall_seen = stall_i;
    end

    initial begin
        int e0;
        logic [31:0] rpc;
        seed = 32'h9a1e0d0f;
        errors = 0;
        n_checked = 0;
        rand_stall = 1'b0;
        stall_seen = 1'b0;
        exp_pc = `FETCH_RESET_PC;
        rst_i = 1'b0;
        stall_i = 1'b0;
        imem_rdata_i = `FETCH_NOP;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        update_valid_i = 1'b0;
        update_pc_i = '0;
        update_taken_i = 1'b0;
        update_target_i = '0;
        for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
            m_ctr[i] = fetch_pkg::WEAK_NT;
            m_valid[i] = 1'b0;
            m_tgt[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            prog[i] = {$random(seed)} & 32'hffff_ff80 | 32'h13; // op-imm words only.
        end
        prog[JAL_PC[9:2]] = make_jal(21'h40);
        prog[BR_PC[9:2]]  = 32'h0020_8463; // beq x1, x2.
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b1;

        e0 = errors;
        wait_instrs(20);
        report_test("test 1 sequential fetch", e0);

        e0 = errors;
        rand_stall = 1'b1;
        wait_instrs(40);
        rand_stall = 1'b0;
        @(posedge clk_i);
        report_test("test 2 random stall", e0);

        e0 = errors;
        rpc = ({$random(seed)} % 112) * 4;
        redirect_cycle(rpc, 1'b0, 1'b0);
        wait_instrs(1);
        check_entry("first after redirect", prev_e, {rpc, prog[rpc[9:2]], 1'b0});
        wait_instrs(8);
        report_test("test 3 external redirect", e0);

        e0 = errors;
        redirect_cycle(JAL_PC - 32'd8, 1'b0, 1'b0);
        wait_pc(JAL_PC);
        wait_instrs(1);
        check_entry("after jal", prev_e, {JAL_PC + 32'h40, prog[(JAL_PC + 32'h40) >> 2], 1'b0});
        report_test("test 4 jal redirect", e0);

        e0 = errors;
        redirect_cycle(BR_PC - 32'd8, 1'b1, 1'b1);
        redirect_cycle(BR_PC - 32'd8, 1'b1, 1'b1);
        check_pred("trained counter", dut_i.bp_i.ctr_q[BR_PC[5:2]], fetch_pkg::STRONG_T);
        wait_pc(BR_PC);
        check_entry("predicted branch", prev_e, {BR_PC, prog[BR_PC[9:2]], 1'b1});
        wait_instrs(1);
        check_entry("branch target", prev_e, {BR_TGT, prog[BR_TGT[9:2]], 1'b0});
        redirect_cycle(BR_PC - 32'd8, 1'b1, 1'b0);
        redirect_cycle(BR_PC - 32'd8, 1'b1, 1'b0);
        check_pred("untrained counter", dut_i.bp_i.ctr_q[BR_PC[5:2]], fetch_pkg::WEAK_NT);
        wait_pc(BR_PC);
        check_entry("unpredicted branch", prev_e, {BR_PC, prog[BR_PC[9:2]], 1'b0});
        report_test("test 5 prediction", e0);

        $display("checked %0d instructions, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
